//--- design/decode_issue.sv
module decode_issue import tiny_core_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,

    input  logic          instr_valid_i,
    input  instr_t        instr_i,
    output logic          instr_pop_o,

    input  logic          stall_i,
    input  logic          wake_i,
    input  writeback_t    writeback_i,
    output issue_packet_t packet_o
);

    typedef enum logic {RUN, WAIT} wfi_state_e;

    wfi_state_e state_q;
    word_t      regs_q [8];
    logic [7:0] busy_q;
    logic [7:0] busy_eff;
    logic [7:0] busy_next;
    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       reads_src;
    logic       writes_rd;
    logic       hazard;
    logic       issue;
    logic       held_store;
    logic       irq_mark;

    // Register read with bypass from the writeback in flight
    function automatic word_t read_reg(reg_idx_t idx);
        if (writeback_i.valid && (writeback_i.rd == idx)) begin
            return writeback_i.data;
        end
        return regs_q[idx];
    endfunction

    // ==============================
    // Decode and hazard check
    // ==============================

    always_comb begin
        opcode = opcode_t'(instr_i[15:12]);
        rd = instr_i[11:9];
        rs1 = instr_i[8:6];
        rs2 = instr_i[5:3];
        writes_rd = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LDI};
        reads_src = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ST};

        // A register written back this cycle counts as free
        busy_eff = busy_q;
        if (writeback_i.valid) begin
            busy_eff[writeback_i.rd] = 1'b0;
        end

        hazard = (reads_src & (busy_eff[rs1] | busy_eff[rs2])) | (writes_rd & busy_eff[rd]);
        issue = instr_valid_i & (state_q == RUN) & ~hazard & ~stall_i;

        // Stall with a ST in the register means a full store buffer
        // Any other stall is execute reserving r7 for an interrupt
        held_store = packet_o.valid & (packet_o.opcode == OP_ST);
        irq_mark = stall_i & ~held_store;

        busy_next = busy_eff;
        if (issue && writes_rd) begin
            busy_next[rd] = 1'b1;
        end
        if (irq_mark) begin
            busy_next[7] = 1'b1;
        end
    end

    assign instr_pop_o = issue;

    // ==============================
    // Register file and issue register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            busy_q <= '0;
            state_q <= RUN;
            packet_o <= '0;
        end else begin
            if (writeback_i.valid) begin
                regs_q[writeback_i.rd] <= writeback_i.data;
            end
            busy_q <= busy_next;

            if (issue) begin
                packet_o <= '{valid: 1'b1, opcode: opcode, rd: rd, op_a: read_reg(rs1),
                              op_b: read_reg(rs2), imm: instr_i[7:0]};
            end else if (!(stall_i && held_store)) begin
                packet_o.valid <= 1'b0;
            end

            // WFI hold
            if (issue && (opcode == OP_WFI)) begin
                state_q <= WAIT;
            end else if ((state_q == WAIT) && wake_i) begin
                state_q <= RUN;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        writeback_i.valid |-> busy_q[writeback_i.rd]);

endmodule

//--- design/execute_unit.sv
module execute_unit import tiny_core_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,

    input  issue_packet_t packet_i,
    input  logic          store_full_i,
    input  logic          raw_int_edge_i,
    input  logic          gated_int_edge_i,
    input  imm_t          interrupt_vector_i,

    output writeback_t    writeback_o,
    output store_req_t    store_o,
    output logic          stall_o,
    output logic          wake_o,
    output logic          int_enable_o,
    output logic          int_ack_o
);

    typedef enum logic [1:0] {IRQ_IDLE, IRQ_WAIT, IRQ_WRITE} irq_state_e;

    irq_state_e irq_state_q;
    irq_state_e irq_state_d;
    imm_t       vector_q;
    word_t      alu_result;
    logic       alu_wb;
    logic       st_in_pkt;
    logic       st_blocked;
    logic       r7_in_pkt;
    logic       irq_pend;
    logic       irq_mark;

    always_comb begin
        alu_wb = packet_i.valid &
                 (packet_i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LDI});
        r7_in_pkt = alu_wb & (packet_i.rd == 3'd7);
        case (packet_i.opcode)
            OP_ADD:  alu_result = packet_i.op_a + packet_i.op_b;
            OP_SUB:  alu_result = packet_i.op_a - packet_i.op_b;
            OP_AND:  alu_result = packet_i.op_a & packet_i.op_b;
            OP_XOR:  alu_result = packet_i.op_a ^ packet_i.op_b;
            OP_LDI:  alu_result = {8'h00, packet_i.imm};
            default: alu_result = '0;
        endcase
    end

    // Stores go straight to the buffer
    // A full buffer holds the ST in the issue register
    assign st_in_pkt = packet_i.valid & (packet_i.opcode == OP_ST);
    assign st_blocked = st_in_pkt & store_full_i;
    assign store_o = '{valid: st_in_pkt & ~store_full_i, addr: packet_i.op_b, data: packet_i.op_a};

    // ==============================
    // Interrupt capture into r7
    // ==============================

    // Stalling once marks r7 busy in decode and leaves a bubble behind
    // The r7 write then takes that free writeback slot
    always_comb begin
        irq_pend = gated_int_edge_i | (irq_state_q == IRQ_WAIT);
        irq_mark = irq_pend & (irq_state_q != IRQ_WRITE) & ~st_in_pkt & ~r7_in_pkt;
        if (irq_state_q == IRQ_WRITE) begin
            irq_state_d = gated_int_edge_i ? IRQ_WAIT : IRQ_IDLE;
        end else if (irq_mark) begin
            irq_state_d = IRQ_WRITE;
        end else if (irq_pend) begin
            irq_state_d = IRQ_WAIT;
        end else begin
            irq_state_d = IRQ_IDLE;
        end
    end

    assign stall_o = st_blocked | irq_mark;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_state_q <= IRQ_IDLE;
            int_enable_o <= 1'b0;
            int_ack_o <= 1'b0;
            wake_o <= 1'b0;
            writeback_o <= '0;
        end else begin
            irq_state_q <= irq_state_d;
            int_ack_o <= gated_int_edge_i;
            wake_o <= raw_int_edge_i;
            if (packet_i.valid && (packet_i.opcode == OP_IEN)) begin
                int_enable_o <= packet_i.imm[0];
            end
            if (irq_state_q == IRQ_WRITE) begin
                writeback_o <= '{valid: 1'b1, rd: 3'd7, data: {8'h00, vector_q}};
            end else begin
                writeback_o <= '{valid: alu_wb, rd: packet_i.rd, data: alu_result};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (gated_int_edge_i) begin
            vector_q <= interrupt_vector_i;
        end
    end

    // Decode must have put a bubble in the issue register for the r7 write
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (irq_state_q == IRQ_WRITE) |-> !packet_i.valid);

endmodule

//--- design/fetch_unit.sv
module fetch_unit import tiny_core_pkg::*; #(
    parameter int INSTR_BUFFER_SIZE = 4
) (
    input  logic   clk_i,
    input  logic   rst_n_i,

    // Fetch channel
    output logic   fetch_req_o,
    output word_t  fetch_addr_o,
    input  logic   fetch_valid_i,
    input  instr_t fetch_instr_i,

    // Towards decode
    output logic   instr_valid_o,
    output instr_t instr_o,
    input  logic   instr_pop_i
);

    localparam int CW = $clog2(INSTR_BUFFER_SIZE + 1);
    localparam int PW = (INSTR_BUFFER_SIZE > 1) ? $clog2(INSTR_BUFFER_SIZE) : 1;

    word_t         pc_q;
    logic [CW-1:0] credit_q;
    logic [CW-1:0] count_q;
    logic [CW-1:0] outstanding_q;
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    instr_t        buffer_q [INSTR_BUFFER_SIZE];
    logic          send;

    // Each credit stands for one buffer slot from request until decode pops it
    assign send = (credit_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_req_o <= 1'b0;
            pc_q <= '0;
            credit_q <= CW'(INSTR_BUFFER_SIZE);
            outstanding_q <= '0;
        end else begin
            fetch_req_o <= send;
            if (send) begin
                pc_q <= pc_q + 16'd1;
            end
            case ({send, instr_pop_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            case ({fetch_req_o, fetch_valid_i})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        fetch_addr_o <= pc_q;
    end

    // In-order instruction buffer
    assign instr_valid_o = (count_q != '0);
    assign instr_o = buffer_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (fetch_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PW'(INSTR_BUFFER_SIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (instr_pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PW'(INSTR_BUFFER_SIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({fetch_valid_i, instr_pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            buffer_q[wr_ptr_q] <= fetch_instr_i;
        end
    end

    // Memory answers each request once, so a return needs one in flight
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i |-> (outstanding_q != '0));

endmodule

//--- design/store_buffer.sv
module store_buffer import tiny_core_pkg::*; #(
    parameter int STORE_BUFFER_SIZE = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  store_req_t store_i,
    output logic       store_full_o,

    // Store channel
    output logic       store_req_o,
    output word_t      store_addr_o,
    output word_t      store_data_o,
    input  logic       store_done_i
);

    localparam int CW = $clog2(STORE_BUFFER_SIZE + 1);
    localparam int PW = (STORE_BUFFER_SIZE > 1) ? $clog2(STORE_BUFFER_SIZE) : 1;

    word_t         addr_q [STORE_BUFFER_SIZE];
    word_t         data_q [STORE_BUFFER_SIZE];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          launch;

    assign store_full_o = (count_q == CW'(STORE_BUFFER_SIZE));

    // Head leaves the FIFO when the channel is idle
    assign launch = ~store_req_o & (count_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            store_req_o <= 1'b0;
        end else begin
            if (store_i.valid) begin
                wr_ptr_q <= (wr_ptr_q == PW'(STORE_BUFFER_SIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (launch) begin
                rd_ptr_q <= (rd_ptr_q == PW'(STORE_BUFFER_SIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({store_i.valid, launch})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Request held until done, then low for at least one cycle
            if (launch) begin
                store_req_o <= 1'b1;
            end else if (store_done_i) begin
                store_req_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_i.valid) begin
            addr_q[wr_ptr_q] <= store_i.addr;
            data_q[wr_ptr_q] <= store_i.data;
        end
        if (launch) begin
            store_addr_o <= addr_q[rd_ptr_q];
            store_data_o <= data_q[rd_ptr_q];
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_i.valid |-> !store_full_o);

endmodule

//--- design/tiny_core.sv
module tiny_core import tiny_core_pkg::*; #(
    parameter int INSTR_BUFFER_SIZE = 4,
    parameter int STORE_BUFFER_SIZE = 4
) (
    input  logic   clk_i,
    input  logic   rst_n_i,

    // Fetch channel
    output logic   fetch_req_o,
    output word_t  fetch_addr_o,
    input  logic   fetch_valid_i,
    input  instr_t fetch_instr_i,

    // Store channel
    output logic   store_req_o,
    output word_t  store_addr_o,
    output word_t  store_data_o,
    input  logic   store_done_i,

    // Interrupt
    input  logic   interrupt_i,
    input  imm_t   interrupt_vector_i,
    output logic   interrupt_ack_o
);

    logic          instr_valid;
    instr_t        instr;
    logic          instr_pop;
    issue_packet_t packet;
    writeback_t    writeback;
    store_req_t    store_req;
    logic          store_full;
    logic          stall;
    logic          wake;
    logic          int_enable;
    logic          int_ack;
    logic          gated_int;
    logic          raw_prev_q;
    logic          gated_prev_q;
    logic          raw_int_edge;
    logic          gated_int_edge;

    // ==============================
    // Interrupt edge detection
    // ==============================

    assign gated_int = interrupt_i & int_enable;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            raw_prev_q <= 1'b0;
            gated_prev_q <= 1'b0;
            raw_int_edge <= 1'b0;
            gated_int_edge <= 1'b0;
            interrupt_ack_o <= 1'b0;
        end else begin
            raw_prev_q <= interrupt_i;
            gated_prev_q <= gated_int;
            raw_int_edge <= interrupt_i & ~raw_prev_q;
            gated_int_edge <= gated_int & ~gated_prev_q;
            interrupt_ack_o <= int_ack;
        end
    end

    // ==============================
    // Front end
    // ==============================

    fetch_unit #(
        .INSTR_BUFFER_SIZE ( INSTR_BUFFER_SIZE )
    ) fetch0 (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .fetch_req_o   ( fetch_req_o   ),
        .fetch_addr_o  ( fetch_addr_o  ),
        .fetch_valid_i ( fetch_valid_i ),
        .fetch_instr_i ( fetch_instr_i ),
        .instr_valid_o ( instr_valid   ),
        .instr_o       ( instr         ),
        .instr_pop_i   ( instr_pop     )
    );

    decode_issue decode0 (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .instr_valid_i ( instr_valid ),
        .instr_i       ( instr       ),
        .instr_pop_o   ( instr_pop   ),
        .stall_i       ( stall       ),
        .wake_i        ( wake        ),
        .writeback_i   ( writeback   ),
        .packet_o      ( packet      )
    );

    // ==============================
    // Back end
    // ==============================

    execute_unit execute0 (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .packet_i           ( packet             ),
        .store_full_i       ( store_full         ),
        .raw_int_edge_i     ( raw_int_edge       ),
        .gated_int_edge_i   ( gated_int_edge     ),
        .interrupt_vector_i ( interrupt_vector_i ),
        .writeback_o        ( writeback          ),
        .store_o            ( store_req          ),
        .stall_o            ( stall              ),
        .wake_o             ( wake               ),
        .int_enable_o       ( int_enable         ),
        .int_ack_o          ( int_ack            )
    );

    store_buffer #(
        .STORE_BUFFER_SIZE ( STORE_BUFFER_SIZE )
    ) store0 (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .store_i      ( store_req    ),
        .store_full_o ( store_full   ),
        .store_req_o  ( store_req_o  ),
        .store_addr_o ( store_addr_o ),
        .store_data_o ( store_data_o ),
        .store_done_i ( store_done_i )
    );

endmodule

//--- design/tiny_core_pkg.sv
package tiny_core_pkg;

    // Instruction layout
    //   [15:12] opcode, [11:9] rd, [8:6] rs1, [5:3] rs2
    //   LDI and IEN take their immediate from [7:0]
    //   ST writes rs1 to the address held in rs2

    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [7:0]  imm_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_XOR = 4'd4,
        OP_LDI = 4'd5,
        OP_ST  = 4'd6,
        OP_IEN = 4'd7,
        OP_WFI = 4'd8
    } opcode_t;

    // Both operands always carry the named registers
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    op_a;
        word_t    op_b;
        imm_t     imm;
    } issue_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } writeback_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_req_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compile and run the tiny_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tiny_core_tb -f tiny_core.f -o tiny_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tiny_core_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation PASSED"
exit 0

//--- tiny_core.f
design/tiny_core_pkg.sv
design/fetch_unit.sv
design/decode_issue.sv
design/execute_unit.sv
design/store_buffer.sv
design/tiny_core.sv
verification/tiny_core_tb.sv

//--- verification/program_input.txt
# P word | S addr data | I store_count vector ack_expected
# All fields hex, S lines in the order the stores must leave the core
P 5212
P 5434
P 1650
P 5810
P 60E0
P 2AC8
P 4D58
P 3B98
P 6160
P 2C50
P 6188
P 6050
P 6098
P 60E8
P 6170
P 61A0
P 6108
P 7001
P 5E55
P 61E0
P 8000
P 61E0
P 7000
P 5620
P 60D8
P 8000
P 61D8
P 1FC8
P 61E0
S 0010 0046
S 0010 0042
S 0012 FFDE
S 0034 0012
S 0046 0034
S 0042 0046
S FFDE 0042
S 0010 FFDE
S 0012 0010
S 0010 0055
S 0010 00A5
S 0020 0020
S 0020 00A5
S 0010 00B7
I A A5 1
I C 3C 0

//--- verification/tiny_core_tb.sv
module tiny_core_tb import tiny_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INSTR_BUFFER_SIZE = 4;
    localparam int STORE_BUFFER_SIZE = 4;

    logic   clk_i = 1'b0;
    logic   rst_n_i = 1'b0;
    logic   fetch_req_o;
    word_t  fetch_addr_o;
    logic   fetch_valid_i = 1'b0;
    instr_t fetch_instr_i = '0;
    logic   store_req_o;
    word_t  store_addr_o;
    word_t  store_data_o;
    logic   store_done_i = 1'b0;
    logic   interrupt_i = 1'b0;
    imm_t   interrupt_vector_i = '0;
    logic   interrupt_ack_o;

    // Contents of the input file
    instr_t prog_q[$];
    word_t  exp_addr_q[$];
    word_t  exp_data_q[$];
    int     irq_pos_q[$];
    imm_t   irq_vec_q[$];
    logic   irq_ack_q[$];

    // Memory model state
    int          due_q[$];
    instr_t      ret_q[$];
    logic [31:0] lfsr_q = 32'h902b_d989;
    int          cycle = 0;
    int          last_due = 0;
    int          outstanding = 0;
    word_t       next_addr = '0;
    int          store_wait = -1;
    int          store_count = 0;

    tiny_core #(
        .INSTR_BUFFER_SIZE ( INSTR_BUFFER_SIZE ),
        .STORE_BUFFER_SIZE ( STORE_BUFFER_SIZE )
    ) dut0 (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .fetch_req_o        ( fetch_req_o        ),
        .fetch_addr_o       ( fetch_addr_o       ),
        .fetch_valid_i      ( fetch_valid_i      ),
        .fetch_instr_i      ( fetch_instr_i      ),
        .store_req_o        ( store_req_o        ),
        .store_addr_o       ( store_addr_o       ),
        .store_data_o       ( store_data_o       ),
        .store_done_i       ( store_done_i       ),
        .interrupt_i        ( interrupt_i        ),
        .interrupt_vector_i ( interrupt_vector_i ),
        .interrupt_ack_o    ( interrupt_ack_o    )
    );

    always #2 clk_i = ~clk_i;

    // ==============================
    // Failure reporting and compares
    // ==============================

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic int unsigned random_bits(input int count);
        int unsigned value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | {31'd0, lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    // ==============================
    // Memory models
    // ==============================

    // Returns come back in order 1 to 4 cycles after the request
    task automatic fetch_model_step();
        int due;
        fetch_valid_i = 1'b0;
        if ((due_q.size() != 0) && (due_q[0] <= cycle)) begin
            fetch_valid_i = 1'b1;
            fetch_instr_i = ret_q.pop_front();
            void'(due_q.pop_front());
            outstanding--;
        end
        if (fetch_req_o === 1'b1) begin
            check_word("fetch_addr_o", fetch_addr_o, next_addr);
            next_addr++;
            due = cycle + 1 + int'(random_bits(2));
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            ret_q.push_back((int'(fetch_addr_o) < prog_q.size()) ? prog_q[fetch_addr_o] : '0);
            outstanding++;
            if (outstanding > INSTR_BUFFER_SIZE) begin
                report_failure($sformatf("%0d fetch requests outstanding", outstanding));
            end
        end
    endtask

    // Done follows the request after 0 to 7 cycles
    task automatic store_model_step();
        if (store_done_i) begin
            store_done_i = 1'b0;
            store_wait = -1;
            check_bit("store_req_o", store_req_o, 1'b0);
        end else if (store_req_o === 1'b1) begin
            if (store_wait < 0) begin
                store_wait = int'(random_bits(3));
            end
            if (store_wait == 0) begin
                if (exp_addr_q.size() == 0) begin
                    report_failure("the core issued more stores than the program holds");
                end
                check_word("store_addr_o", store_addr_o, exp_addr_q.pop_front());
                check_word("store_data_o", store_data_o, exp_data_q.pop_front());
                store_count++;
                store_done_i = 1'b1;
            end else begin
                store_wait--;
            end
        end
    endtask

    always @(negedge clk_i) begin
        cycle++;
        if (rst_n_i) begin
            fetch_model_step();
            store_model_step();
        end
    end

    // ==============================
    // Interrupt pulses
    // ==============================

    task automatic pulse_interrupt(input int position, input imm_t vector, input logic ack);
        int waited;
        waited = 0;
        while (store_count < position) begin
            @(negedge clk_i);
            waited++;
            if (waited > 2000) begin
                report_failure($sformatf("store count stuck at %0d before interrupt at %0d",
                                         store_count, position));
            end
        end
        // Give the WFI time to reach decode
        repeat (12) @(negedge clk_i);
        check_bit("interrupt_ack_o", interrupt_ack_o, 1'b0);
        interrupt_vector_i = vector;
        interrupt_i = 1'b1;
        for (int k = 1; k <= 20; k++) begin
            @(negedge clk_i);
            if (k == 2) begin
                interrupt_i = 1'b0;
            end
            check_bit("interrupt_ack_o", interrupt_ack_o, ack && (k == 3));
        end
    endtask

    initial begin
        int          fd;
        int          waited;
        int          total;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        fd = $fopen("verification/program_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/program_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            kind = 8'h00;
            void'($fgets(line, fd));
            void'($sscanf(line, "%c %h %h %h", kind, a, b, c));
            case (kind)
                "P": prog_q.push_back(a[15:0]);
                "S": begin
                    exp_addr_q.push_back(a[15:0]);
                    exp_data_q.push_back(b[15:0]);
                end
                "I": begin
                    irq_pos_q.push_back(int'(a));
                    irq_vec_q.push_back(b[7:0]);
                    irq_ack_q.push_back(c[0]);
                end
                default: ;
            endcase
        end
        $fclose(fd);
        total = exp_addr_q.size();

        // Outputs must be idle after 8 cycles of reset
        repeat (8) @(negedge clk_i);
        check_bit("fetch_req_o", fetch_req_o, 1'b0);
        check_bit("store_req_o", store_req_o, 1'b0);
        check_bit("interrupt_ack_o", interrupt_ack_o, 1'b0);
        rst_n_i = 1'b1;

        for (int i = 0; i < irq_pos_q.size(); i++) begin
            pulse_interrupt(irq_pos_q[i], irq_vec_q[i], irq_ack_q[i]);
        end

        waited = 0;
        while (store_count < total) begin
            @(negedge clk_i);
            waited++;
            if (waited > 4000) begin
                report_failure($sformatf("only %0d of %0d stores arrived", store_count, total));
            end
        end
        // Quiet window for stray stores
        repeat (20) @(negedge clk_i);

        $display("%0d stores checked in %0d cycles", store_count, cycle);
        $display("Test completed successfully");
        $finish;
    end

endmodule
